//--- src.f
verilog/cpuPkg.sv
verilog/decodeCtrlIf.sv
verilog/operandIf.sv
verilog/controlDecoder.sv
verilog/regFile.sv
verilog/operandFetch.sv
verilog/idExRegister.sv
verilog/decodeStage.sv
test/decodeStage_sva.sv
test/decodeStageTb.sv

//--- test/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;

    localparam int pcWidth   = 32;
    localparam int clkPeriod = 100;
    // Reset, then each test in run order
    localparam int testCycles = 4 + 16 + 27 + 22 + 7 + 6 + 48;

    logic               Clk, arstN, rfWe, fetchValid, fetchPredTaken, stall, flush, fwdRs2Sel;
    logic [4:0]         wAddr, exRd, exRs1, exRs2, rs2Addr;
    logic [31:0]        wData, fetchInstr, fwdRs2, exOp1, exOp2, exImm;
    logic [pcWidth-1:0] fetchPc, exPc, ePc;
    logic               exValid, exPredTaken, exReti, needRs2;
    logic [5:0]         exCtrl, eEx, dEx;
    logic [1:0]         maCtrl, wbCtrl, eMa, eWb, dMa, dWb;

    // Shadow registers, expected outputs, decoded fields
    logic [31:0] shadow [32];
    logic        eValid, ePred, eReti, dReti, dNeed, dFromRd;
    logic [4:0]  eRd, eRs1, eRs2;
    logic [31:0] eOp1, eOp2, eImm, dImm;
    integer      seed = 32'h139493e3;
    string       testName;

    decodeStage #(.pcWidth(pcWidth)) dut (.*);

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        #((testCycles + 40) * clkPeriod);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    // Bound assertion failures end the run
    initial begin
        wait (dut.uSva.failCount != 0);
        $display("A bound assertion failed, see the error above");
        $display("Done: errors found");
        $fatal(1, "assertion failure");
    end

    function automatic logic [31:0] randWord();
        return $random(seed);
    endfunction

    function automatic logic [31:0] aluInstr(input logic [4:0] rs1, input logic [4:0] rs2);
        return {cpuPkg::opAlu, 5'd3, rs1, rs2, 11'h002};
    endfunction

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s %s: expected %h actual %h", testName, what, expected, actual);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkOutputs();
        checkValue("exValid", eValid, exValid);
        checkValue("exPc", ePc, exPc);
        checkValue("exPredTaken", ePred, exPredTaken);
        checkValue("exRd", eRd, exRd);
        checkValue("exRs1", eRs1, exRs1);
        checkValue("exRs2", eRs2, exRs2);
        checkValue("exOp1", eOp1, exOp1);
        checkValue("exOp2", eOp2, exOp2);
        checkValue("exImm", eImm, exImm);
        checkValue("exCtrl", eEx, exCtrl);
        checkValue("maCtrl", eMa, maCtrl);
        checkValue("wbCtrl", eWb, wbCtrl);
        checkValue("exReti", eReti, exReti);
    endtask

    ///////////////////////////////
    // Decode rules per opcode
    ///////////////////////////////
    task automatic predict(input logic [31:0] ins);
        logic [3:0] alu;
        logic       src, br, mr, mw, rw, m2r;
        logic [1:0] kind;
        alu = cpuPkg::aluAdd;
        kind = cpuPkg::immSigned;
        {src, br, mr, mw, rw, m2r, dReti, dNeed, dFromRd} = '0;
        case (ins[31:26])
            cpuPkg::opAlu: begin
                alu = ins[3:0];
                {rw, dNeed} = 2'b11;
            end
            cpuPkg::opAddi: {src, rw} = 2'b11;
            cpuPkg::opAndi: begin
                alu = cpuPkg::aluAnd;
                kind = cpuPkg::immZero;
                {src, rw} = 2'b11;
            end
            cpuPkg::opOri: begin
                alu = cpuPkg::aluOr;
                kind = cpuPkg::immZero;
                {src, rw} = 2'b11;
            end
            cpuPkg::opLui: begin
                alu = cpuPkg::aluPassB;
                kind = cpuPkg::immUpper;
                {src, rw} = 2'b11;
            end
            cpuPkg::opLoad: {src, mr, rw, m2r} = 4'b1111;
            cpuPkg::opStore: {src, mw, dNeed, dFromRd} = 4'b1111;
            cpuPkg::opBeq: begin
                alu = cpuPkg::aluSub;
                {br, dNeed, dFromRd} = 3'b111;
            end
            cpuPkg::opReti: dReti = 1'b1;
            default: ;
        endcase
        dEx = {br, src, alu};
        dMa = {mw, mr};
        dWb = {m2r, rw};
        case (kind)
            cpuPkg::immZero:  dImm = {16'h0000, ins[15:0]};
            cpuPkg::immUpper: dImm = {ins[15:0], 16'h0000};
            default:          dImm = {{16{ins[15]}}, ins[15:0]};
        endcase
    endtask

    // Called at a falling edge, returns at the next one with outputs checked
    task automatic issue(input logic [31:0] ins, input logic valid, input logic st,
                         input logic fl, input logic fsel, input logic [31:0] fval);
        logic [4:0]  rs2Sel;
        logic [31:0] rnd;
        rnd = randWord();
        {fetchInstr, fetchValid, fetchPc, fetchPredTaken} = {ins, valid, randWord(), rnd[0]};
        {stall, flush, fwdRs2Sel, fwdRs2} = {st, fl, fsel, fval};
        predict(ins);
        rs2Sel = dFromRd ? ins[25:21] : ins[15:11];
        // Same-cycle write is visible to this decode
        if (rfWe && wAddr != 5'd0) shadow[wAddr] = wData;
        #(clkPeriod / 10);
        checkValue("needRs2", dNeed, needRs2);
        checkValue("rs2Addr", rs2Sel, rs2Addr);
        if (fl || !st) begin
            {ePc, ePred, eValid} = {fetchPc, rnd[0], valid && !fl};
            {eRd, eRs1, eRs2, eOp1, eOp2, eImm, eEx, eMa, eWb, eReti} = '0;
            if (eValid) begin
                {eRd, eRs1, eRs2} = {ins[25:21], ins[20:16], rs2Sel};
                eOp1 = shadow[ins[20:16]];
                eOp2 = fsel ? fval : shadow[rs2Sel];
                {eImm, eEx, eMa, eWb, eReti} = {dImm, dEx, dMa, dWb, dReti};
            end
        end
        @(posedge Clk);
        @(negedge Clk);
        {rfWe, stall, flush, fwdRs2Sel} = '0;
        checkOutputs();
    endtask

    task automatic issueValid(input logic [31:0] ins);
        issue(ins, 1'b1, 1'b0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic writeReg(input logic [4:0] addr, input logic [31:0] data);
        {rfWe, wAddr, wData} = {1'b1, addr, data};
        issue(32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
    endtask

    ///////////////////////////////
    // Tests
    ///////////////////////////////
    task automatic testReset();
        testName = "reset";
        checkValue("exValid", 0, exValid);
        checkValue("exCtrl", 0, exCtrl);
        checkValue("maCtrl", 0, maCtrl);
        checkValue("wbCtrl", 0, wbCtrl);
        checkValue("exReti", 0, exReti);
        for (int i = 0; i < 32; i += 2) begin
            issueValid(aluInstr(5'(i), 5'(i + 1)));
        end
    endtask

    task automatic testRegFile();
        logic [31:0] r;
        testName = "regFile";
        repeat (12) begin
            r = randWord();
            writeReg(r[4:0], randWord());
            issueValid(aluInstr(r[4:0], r[9:5]));
        end
        writeReg(5'd0, 32'hdead_beef);
        issueValid(aluInstr(5'd0, 5'd0));
        // Write-through
        {rfWe, wAddr, wData} = {1'b1, 5'd9, randWord()};
        issueValid(aluInstr(5'd9, 5'd9));
    endtask

    task automatic testDecode();
        logic [31:0] r;
        testName = "decode";
        repeat (2) begin
            for (int op = 0; op <= 10; op++) begin
                r = randWord();
                issueValid({(op == 10) ? 6'h2a : 6'(op), r[25:0]});
            end
        end
    endtask

    task automatic testForward();
        logic [31:0] r;
        testName = "forward";
        repeat (3) begin
            r = randWord();
            writeReg(r[4:0], randWord());
            issue(aluInstr(r[9:5], r[4:0]), 1'b1, 1'b0, 1'b0, 1'b1, randWord());
        end
        issue({cpuPkg::opStore, 5'd5, 5'd6, 16'h0010}, 1'b1, 1'b0, 1'b0, 1'b1, randWord());
    endtask

    task automatic testFlow();
        testName = "flow";
        issueValid(aluInstr(5'd1, 5'd2));
        issue({cpuPkg::opAddi, 26'h0ab_cdef}, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0);
        issue({cpuPkg::opLoad, 26'h123_4567}, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0);
        issueValid({cpuPkg::opOri, 26'h2f0_8001});
        issue({cpuPkg::opBeq, 26'h155_5555}, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0);
        issue({cpuPkg::opLui, 26'h0f0_f0f0}, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic testStream();
        logic [31:0] r, w;
        logic [5:0]  op;
        testName = "stream";
        repeat (48) begin
            r = randWord();
            w = randWord();
            op = r[31:26] % 6'd10;
            {rfWe, wAddr, wData} = {w[0], w[5:1], randWord()};
            issueValid({op, r[25:0]});
        end
    endtask

    initial begin
        {arstN, rfWe, wAddr, wData, fetchInstr, fetchPc} = '0;
        {fetchValid, fetchPredTaken, stall, flush, fwdRs2, fwdRs2Sel} = '0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;
        testReset();
        testRegFile();
        testDecode();
        testForward();
        testFlow();
        testStream();
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- test/decodeStage_sva.sv
`timescale 1ns/1ps

module decodeStageSva #(
    parameter int pcWidth = 32
) (
    input logic                Clk,
    input logic                arstN,
    input logic                stall,
    input logic                flush,
    input logic                exValid,
    input logic [pcWidth-1:0]  exPc,
    input logic                exPredTaken,
    input logic [4:0]          exRd,
    input logic [4:0]          exRs1,
    input logic [4:0]          exRs2,
    input logic [31:0]         exOp1,
    input logic [31:0]         exOp2,
    input logic [31:0]         exImm,
    input logic [5:0]          exCtrl,
    input logic [1:0]          maCtrl,
    input logic [1:0]          wbCtrl,
    input logic                exReti
);

    // Count of assertion failures
    int failCount = 0;

    resetClearsValid: assert property (@(posedge Clk) !arstN |-> !exValid)
        else begin
            failCount++;
            $error("exValid high while in reset");
        end

    // Stall without flush freezes the stage register
    stallHolds: assert property (@(posedge Clk) disable iff (!arstN)
        (stall && !flush) |=> $stable(exValid) && $stable(exPc) && $stable(exPredTaken)
            && $stable(exRd) && $stable(exRs1) && $stable(exRs2)
            && $stable(exOp1) && $stable(exOp2) && $stable(exImm)
            && $stable(exCtrl) && $stable(maCtrl) && $stable(wbCtrl) && $stable(exReti))
        else begin
            failCount++;
            $error("outputs changed across a stalled edge");
        end

    flushBubbles: assert property (@(posedge Clk) disable iff (!arstN)
        flush |=> !exValid && exCtrl == '0 && maCtrl == '0 && wbCtrl == '0 && !exReti)
        else begin
            failCount++;
            $error("flush did not load a bubble");
        end

endmodule

bind decodeStage decodeStageSva #(.pcWidth(pcWidth)) uSva (
    .Clk(Clk), .arstN(arstN), .stall(stall), .flush(flush), .exValid(exValid),
    .exPc(exPc), .exPredTaken(exPredTaken), .exRd(exRd), .exRs1(exRs1), .exRs2(exRs2),
    .exOp1(exOp1), .exOp2(exOp2), .exImm(exImm), .exCtrl(exCtrl), .maCtrl(maCtrl),
    .wbCtrl(wbCtrl), .exReti(exReti)
);

//--- verilog/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
    input  cpuPkg::instrWord instr,
    decodeCtrlIf.decoder     ctrl
);

    logic [cpuPkg::aluWidth-1:0] aluCode;
    logic                        aluSrcImm;
    logic                        branch;
    logic                        memRead;
    logic                        memWrite;
    logic                        regWrite;
    logic                        memToReg;

    //////////////////////////////
    // Opcode decode
    //////////////////////////////
    always_comb begin
        ctrl.signExtCtrl = cpuPkg::immSigned;
        ctrl.rs2FromRd   = 1'b0;
        ctrl.reti        = 1'b0;
        ctrl.needRs2     = 1'b0;
        aluCode          = cpuPkg::aluAdd;
        aluSrcImm        = 1'b0;
        branch           = 1'b0;
        memRead          = 1'b0;
        memWrite         = 1'b0;
        regWrite         = 1'b0;
        memToReg         = 1'b0;

        case (instr.r.opcode)
            cpuPkg::opAlu: begin
                aluCode      = instr.r.funct[cpuPkg::aluWidth-1:0];
                regWrite     = 1'b1;
                ctrl.needRs2 = 1'b1;
            end
            cpuPkg::opAddi: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            cpuPkg::opAndi: begin
                ctrl.signExtCtrl = cpuPkg::immZero;
                aluCode          = cpuPkg::aluAnd;
                aluSrcImm        = 1'b1;
                regWrite         = 1'b1;
            end
            cpuPkg::opOri: begin
                ctrl.signExtCtrl = cpuPkg::immZero;
                aluCode          = cpuPkg::aluOr;
                aluSrcImm        = 1'b1;
                regWrite         = 1'b1;
            end
            cpuPkg::opLui: begin
                ctrl.signExtCtrl = cpuPkg::immUpper;
                aluCode          = cpuPkg::aluPassB;
                aluSrcImm        = 1'b1;
                regWrite         = 1'b1;
            end
            cpuPkg::opLoad: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                regWrite  = 1'b1;
                memToReg  = 1'b1;
            end
            // Store data comes from the register named by rd
            cpuPkg::opStore: begin
                aluSrcImm      = 1'b1;
                memWrite       = 1'b1;
                ctrl.rs2FromRd = 1'b1;
                ctrl.needRs2   = 1'b1;
            end
            cpuPkg::opBeq: begin
                aluCode        = cpuPkg::aluSub;
                branch         = 1'b1;
                ctrl.rs2FromRd = 1'b1;
                ctrl.needRs2   = 1'b1;
            end
            cpuPkg::opReti: ctrl.reti = 1'b1;
            // Nop and unknown opcodes keep the defaults
            cpuPkg::opNop: ;
            default: ;
        endcase
    end

    // Pack the stage fields
    always_comb begin
        ctrl.exCtrl[cpuPkg::exAluLsb +: cpuPkg::aluWidth] = aluCode;
        ctrl.exCtrl[cpuPkg::exAluSrcBit]                  = aluSrcImm;
        ctrl.exCtrl[cpuPkg::exBranchBit]                  = branch;
        ctrl.maCtrl[cpuPkg::maReadBit]                    = memRead;
        ctrl.maCtrl[cpuPkg::maWriteBit]                   = memWrite;
        ctrl.wbCtrl[cpuPkg::wbRegWriteBit]                = regWrite;
        ctrl.wbCtrl[cpuPkg::wbMemToRegBit]                = memToReg;
    end

endmodule

//--- verilog/cpuPkg.sv
package cpuPkg;

    //////////////////////////////
    // Datapath sizes
    //////////////////////////////
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int opcodeWidth  = 6;
    localparam int aluWidth     = 4;
    localparam int immKindWidth = 2;

    // One instruction word, two field layouts
    typedef union packed {
        struct packed {
            logic [opcodeWidth-1:0]  opcode;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs1;
            logic [regAddrWidth-1:0] rs2;
            logic [10:0]             funct;
        } r;
        struct packed {
            logic [opcodeWidth-1:0]  opcode;
            logic [regAddrWidth-1:0] rd;
            logic [regAddrWidth-1:0] rs1;
            logic [15:0]             imm;
        } i;
    } instrWord;

    //////////////////////////////
    // Opcodes
    //////////////////////////////
    localparam logic [opcodeWidth-1:0] opNop   = 6'd0;
    localparam logic [opcodeWidth-1:0] opAlu   = 6'd1;
    localparam logic [opcodeWidth-1:0] opAddi  = 6'd2;
    localparam logic [opcodeWidth-1:0] opAndi  = 6'd3;
    localparam logic [opcodeWidth-1:0] opOri   = 6'd4;
    localparam logic [opcodeWidth-1:0] opLui   = 6'd5;
    localparam logic [opcodeWidth-1:0] opLoad  = 6'd6;
    localparam logic [opcodeWidth-1:0] opStore = 6'd7;
    localparam logic [opcodeWidth-1:0] opBeq   = 6'd8;
    localparam logic [opcodeWidth-1:0] opReti  = 6'd9;

    // ALU operations, register format takes them from funct
    localparam logic [aluWidth-1:0] aluAdd   = 4'd0;
    localparam logic [aluWidth-1:0] aluSub   = 4'd1;
    localparam logic [aluWidth-1:0] aluAnd   = 4'd2;
    localparam logic [aluWidth-1:0] aluOr    = 4'd3;
    localparam logic [aluWidth-1:0] aluXor   = 4'd4;
    localparam logic [aluWidth-1:0] aluSlt   = 4'd5;
    localparam logic [aluWidth-1:0] aluSll   = 4'd6;
    localparam logic [aluWidth-1:0] aluSrl   = 4'd7;
    localparam logic [aluWidth-1:0] aluPassB = 4'd8;

    // Immediate kinds
    localparam logic [immKindWidth-1:0] immSigned = 2'd0;
    localparam logic [immKindWidth-1:0] immZero   = 2'd1;
    localparam logic [immKindWidth-1:0] immUpper  = 2'd2;

    //////////////////////////////
    // Control fields
    //////////////////////////////
    localparam int exWidth = 6;
    localparam int maWidth = 2;
    localparam int wbWidth = 2;

    localparam int exAluLsb    = 0;
    localparam int exAluSrcBit = 4;
    localparam int exBranchBit = 5;

    localparam int maReadBit  = 0;
    localparam int maWriteBit = 1;

    localparam int wbRegWriteBit = 0;
    localparam int wbMemToRegBit = 1;

endpackage

//--- verilog/decodeCtrlIf.sv
`timescale 1ns/1ps

interface decodeCtrlIf;

    // Operand side
    logic [cpuPkg::immKindWidth-1:0] signExtCtrl;
    logic                            rs2FromRd;

    // Stage controls carried down the pipe
    logic [cpuPkg::exWidth-1:0] exCtrl;
    logic [cpuPkg::maWidth-1:0] maCtrl;
    logic [cpuPkg::wbWidth-1:0] wbCtrl;
    logic                       reti;

    // For the forwarding unit
    logic needRs2;

    modport decoder (
        output signExtCtrl, rs2FromRd, exCtrl, maCtrl, wbCtrl, reti, needRs2
    );

    modport fetch (input signExtCtrl, rs2FromRd);

    modport pipe (input exCtrl, maCtrl, wbCtrl, reti);

endinterface

//--- verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
    parameter int pcWidth = 32
) (
    input  logic                              Clk,
    input  logic                              arstN,
    // Writeback port
    input  logic                              rfWe,
    input  logic [cpuPkg::regAddrWidth-1:0]   wAddr,
    input  logic [cpuPkg::dataWidth-1:0]      wData,
    // From fetch
    input  logic [31:0]                       fetchInstr,
    input  logic [pcWidth-1:0]                fetchPc,
    input  logic                              fetchValid,
    input  logic                              fetchPredTaken,
    // Flow control
    input  logic                              stall,
    input  logic                              flush,
    // Forwarding override
    input  logic [cpuPkg::dataWidth-1:0]      fwdRs2,
    input  logic                              fwdRs2Sel,
    // To execute
    output logic                              exValid,
    output logic [pcWidth-1:0]                exPc,
    output logic                              exPredTaken,
    output logic [cpuPkg::regAddrWidth-1:0]   exRd,
    output logic [cpuPkg::regAddrWidth-1:0]   exRs1,
    output logic [cpuPkg::regAddrWidth-1:0]   exRs2,
    output logic [cpuPkg::dataWidth-1:0]      exOp1,
    output logic [cpuPkg::dataWidth-1:0]      exOp2,
    output logic [cpuPkg::dataWidth-1:0]      exImm,
    output logic [cpuPkg::exWidth-1:0]        exCtrl,
    output logic [cpuPkg::maWidth-1:0]        maCtrl,
    output logic [cpuPkg::wbWidth-1:0]        wbCtrl,
    output logic                              exReti,
    // To the forwarding unit
    output logic                              needRs2,
    output logic [cpuPkg::regAddrWidth-1:0]   rs2Addr
);

    cpuPkg::instrWord                instr;
    logic [cpuPkg::regAddrWidth-1:0] rAddrA;
    logic [cpuPkg::regAddrWidth-1:0] rAddrB;
    logic [cpuPkg::dataWidth-1:0]    rDataA;
    logic [cpuPkg::dataWidth-1:0]    rDataB;

    decodeCtrlIf ctrlIf ();
    operandIf    opIf ();

    assign instr   = fetchInstr;
    assign needRs2 = ctrlIf.needRs2;
    assign rs2Addr = opIf.rs2Addr;

    controlDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrlIf.decoder)
    );

    operandFetch uFetch (
        .instr     (instr),
        .fwdRs2    (fwdRs2),
        .fwdRs2Sel (fwdRs2Sel),
        .ctrl      (ctrlIf.fetch),
        .ops       (opIf.source),
        .rAddrA    (rAddrA),
        .rAddrB    (rAddrB),
        .rDataA    (rDataA),
        .rDataB    (rDataB)
    );

    regFile uRegFile (
        .Clk    (Clk),
        .arstN  (arstN),
        .we     (rfWe),
        .wAddr  (wAddr),
        .wData  (wData),
        .rAddrA (rAddrA),
        .rAddrB (rAddrB),
        .rDataA (rDataA),
        .rDataB (rDataB)
    );

    idExRegister #(
        .pcWidth (pcWidth)
    ) uIdEx (
        .Clk         (Clk),
        .arstN       (arstN),
        .stall       (stall),
        .flush       (flush),
        .inValid     (fetchValid),
        .inPc        (fetchPc),
        .inPredTaken (fetchPredTaken),
        .ctrl        (ctrlIf.pipe),
        .ops         (opIf.sink),
        .exValid     (exValid),
        .exPc        (exPc),
        .exPredTaken (exPredTaken),
        .exRd        (exRd),
        .exRs1       (exRs1),
        .exRs2       (exRs2),
        .exOp1       (exOp1),
        .exOp2       (exOp2),
        .exImm       (exImm),
        .exCtrl      (exCtrl),
        .maCtrl      (maCtrl),
        .wbCtrl      (wbCtrl),
        .exReti      (exReti)
    );

endmodule

//--- verilog/idExRegister.sv
`timescale 1ns/1ps

module idExRegister #(
    parameter int pcWidth = 32
) (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              inValid,
    input  logic [pcWidth-1:0]                inPc,
    input  logic                              inPredTaken,
    decodeCtrlIf.pipe                         ctrl,
    operandIf.sink                            ops,
    output logic                              exValid,
    output logic [pcWidth-1:0]                exPc,
    output logic                              exPredTaken,
    output logic [cpuPkg::regAddrWidth-1:0]   exRd,
    output logic [cpuPkg::regAddrWidth-1:0]   exRs1,
    output logic [cpuPkg::regAddrWidth-1:0]   exRs2,
    output logic [cpuPkg::dataWidth-1:0]      exOp1,
    output logic [cpuPkg::dataWidth-1:0]      exOp2,
    output logic [cpuPkg::dataWidth-1:0]      exImm,
    output logic [cpuPkg::exWidth-1:0]        exCtrl,
    output logic [cpuPkg::maWidth-1:0]        maCtrl,
    output logic [cpuPkg::wbWidth-1:0]        wbCtrl,
    output logic                              exReti
);

    logic load;
    logic bubble;

    // Flush wins over stall
    assign load   = flush || !stall;
    assign bubble = flush || !inValid;

    //////////////////////////////
    // Control half
    //////////////////////////////
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
            exCtrl  <= '0;
            maCtrl  <= '0;
            wbCtrl  <= '0;
            exReti  <= 1'b0;
        end else if (load) begin
            exValid <= !bubble;
            exCtrl  <= bubble ? '0 : ctrl.exCtrl;
            maCtrl  <= bubble ? '0 : ctrl.maCtrl;
            wbCtrl  <= bubble ? '0 : ctrl.wbCtrl;
            exReti  <= !bubble && ctrl.reti;
        end
    end

    // Payload half, zeroed for a bubble
    always_ff @(posedge Clk) begin
        if (load) begin
            exPc        <= inPc;
            exPredTaken <= inPredTaken;
            exRd        <= bubble ? '0 : ops.rdAddr;
            exRs1       <= bubble ? '0 : ops.rs1Addr;
            exRs2       <= bubble ? '0 : ops.rs2Addr;
            exOp1       <= bubble ? '0 : ops.op1;
            exOp2       <= bubble ? '0 : ops.op2;
            exImm       <= bubble ? '0 : ops.imm;
        end
    end

endmodule

//--- verilog/operandFetch.sv
`timescale 1ns/1ps

module operandFetch (
    input  cpuPkg::instrWord                 instr,
    input  logic [cpuPkg::dataWidth-1:0]     fwdRs2,
    input  logic                             fwdRs2Sel,
    decodeCtrlIf.fetch                       ctrl,
    operandIf.source                         ops,
    output logic [cpuPkg::regAddrWidth-1:0]  rAddrA,
    output logic [cpuPkg::regAddrWidth-1:0]  rAddrB,
    input  logic [cpuPkg::dataWidth-1:0]     rDataA,
    input  logic [cpuPkg::dataWidth-1:0]     rDataB
);

    logic [cpuPkg::regAddrWidth-1:0] rs1Sel;
    logic [cpuPkg::regAddrWidth-1:0] rs2Sel;
    logic [15:0]                     imm16;

    //////////////////////////////
    // Register addressing
    //////////////////////////////
    assign rs1Sel = instr.r.rs1;

    // Store and beq read their second source through rd
    assign rs2Sel = ctrl.rs2FromRd ? instr.r.rd : instr.r.rs2;

    assign rAddrA      = rs1Sel;
    assign rAddrB      = rs2Sel;
    assign ops.rdAddr  = instr.r.rd;
    assign ops.rs1Addr = rs1Sel;
    assign ops.rs2Addr = rs2Sel;

    // Operands, rs2 may be overridden by the forwarding unit
    assign ops.op1 = rDataA;
    assign ops.op2 = fwdRs2Sel ? fwdRs2 : rDataB;

    //////////////////////////////
    // Immediate
    //////////////////////////////
    assign imm16 = instr.i.imm;

    always_comb begin
        case (ctrl.signExtCtrl)
            cpuPkg::immZero:  ops.imm = {16'h0000, imm16};
            cpuPkg::immUpper: ops.imm = {imm16, 16'h0000};
            default:          ops.imm = {{16{imm16[15]}}, imm16};
        endcase
    end

endmodule

//--- verilog/operandIf.sv
`timescale 1ns/1ps

interface operandIf;

    // Register addresses
    logic [cpuPkg::regAddrWidth-1:0] rdAddr;
    logic [cpuPkg::regAddrWidth-1:0] rs1Addr;
    logic [cpuPkg::regAddrWidth-1:0] rs2Addr;

    // Operand values
    logic [cpuPkg::dataWidth-1:0] op1;
    logic [cpuPkg::dataWidth-1:0] op2;
    logic [cpuPkg::dataWidth-1:0] imm;

    modport source (
        output rdAddr, rs1Addr, rs2Addr, op1, op2, imm
    );

    modport sink (
        input rdAddr, rs1Addr, rs2Addr, op1, op2, imm
    );

endinterface

//--- verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                              Clk,
    input  logic                              arstN,
    input  logic                              we,
    input  logic [cpuPkg::regAddrWidth-1:0]   wAddr,
    input  logic [cpuPkg::dataWidth-1:0]      wData,
    input  logic [cpuPkg::regAddrWidth-1:0]   rAddrA,
    input  logic [cpuPkg::regAddrWidth-1:0]   rAddrB,
    output logic [cpuPkg::dataWidth-1:0]      rDataA,
    output logic [cpuPkg::dataWidth-1:0]      rDataB
);

    localparam int depth = 2 ** cpuPkg::regAddrWidth;

    logic [cpuPkg::dataWidth-1:0] regs [depth];
    logic                         writeEn;

    // Register zero is never written
    assign writeEn = we && (wAddr != '0);

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < depth; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wAddr] <= wData;
        end
    end

    // Read with write-through from the writeback port
    function automatic logic [cpuPkg::dataWidth-1:0] readPort(
        input logic [cpuPkg::regAddrWidth-1:0] addr
    );
        if (addr == '0) begin
            return '0;
        end else if (writeEn && (addr == wAddr)) begin
            return wData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rDataA = readPort(rAddrA);
        rDataB = readPort(rAddrB);
    end

endmodule
